//--- verilog/touch_defs.svh
`ifndef TOUCH_DEFS_SVH
`define TOUCH_DEFS_SVH

// ========================================
// widths
// ========================================
`define DATA_W    8  // register / byte
`define RX_W      16 // opcode byte + argument byte
`define TX_W      32 // one frame to the pc
`define TOUCH_W   12 // electrodes 0..11
`define SET_COUNT 14 // recommended setting registers

// uart opcodes
`define OP_RUN      8'h52 // 'R'
`define OP_STOP     8'h53 // 'S'
`define OP_READ_REG 8'h6D // 'm'

// frame tags
`define TAG_TOUCH 8'hBB
`define TAG_REG   8'h6D

// mpr121 registers and values
`define REG_TOUCH0  8'h00 // ele0..7, read only
`define REG_TOUCH1  8'h01 // ele8..11 in bits 3..0
`define REG_ELE_CFG 8'h5E // electrode enable
`define ELE_RUN     8'h8F // all twelve electrodes on
`define ELE_STOP    8'h00

// setting table, {address, data}
`define SET_PAIR_0  16'h2B01 // mhd rising
`define SET_PAIR_1  16'h2C01 // nhd rising
`define SET_PAIR_2  16'h2D0E // ncl rising
`define SET_PAIR_3  16'h2E00 // fdl rising
`define SET_PAIR_4  16'h2F01 // mhd falling
`define SET_PAIR_5  16'h3005 // nhd falling
`define SET_PAIR_6  16'h3101 // ncl falling
`define SET_PAIR_7  16'h3200 // fdl falling
`define SET_PAIR_8  16'h3300 // nhd touched
`define SET_PAIR_9  16'h3400 // ncl touched
`define SET_PAIR_10 16'h3500 // fdl touched
`define SET_PAIR_11 16'h5B00 // debounce
`define SET_PAIR_12 16'h5C10 // afe config
`define SET_PAIR_13 16'h5D20 // filter config

`endif

//--- verilog/touch_pkg.sv
`include "touch_defs.svh"

package touch_pkg;

	typedef logic [`DATA_W-1:0] data_t; // one register byte

	// pc command opcodes, upper byte of a command
	typedef enum logic [`DATA_W-1:0] {
		CMD_RUN      = `OP_RUN,
		CMD_STOP     = `OP_STOP,
		CMD_READ_REG = `OP_READ_REG
	} pc_cmd_e;

	// ========================================
	// state encodings
	// ========================================
	typedef enum logic [2:0] {
		CORE_IDLE, CORE_WAIT_INIT, CORE_CHIP_SET, CORE_STANDBY, CORE_READING
	} core_state_e;

	typedef enum logic [3:0] {
		MPR_IDLE, MPR_SETTING, MPR_RUN, MPR_STOP,
		MPR_XFER_LOAD, MPR_XFER_EN, MPR_XFER_WAIT, // shared register transfer
		MPR_POLL_LOAD, MPR_POLL_CHANGE, MPR_ERROR
	} mpr_state_e;

	// toward the i2c engine
	typedef struct packed {
		data_t reg_addr;
		data_t data_in;
		logic  write_en; // one cycle strobe
		logic  read_en;  // one cycle strobe
	} mpr_req_t;

	// back from the i2c engine
	typedef struct packed {
		data_t data_out; // valid on the first cycle busy is low
		logic  init_set;
		logic  busy;
		logic  fail;
	} mpr_rsp_t;

	typedef struct packed {
		data_t addr;
		data_t data;
	} reg_reply_t;

endpackage

//--- verilog/mpr_setting_rom.sv
`timescale 1ns/10ps
`include "touch_defs.svh"

module mpr_setting_rom import touch_pkg::*; (
	input  logic [3:0] i_index, // table position 0..13
	output data_t      o_reg_addr,
	output data_t      o_reg_data
);

	// datasheet recommended order, data 0x20 for 0x5D
	always_comb begin
		case (i_index)
			4'd0:    {o_reg_addr, o_reg_data} = `SET_PAIR_0;
			4'd1:    {o_reg_addr, o_reg_data} = `SET_PAIR_1;
			4'd2:    {o_reg_addr, o_reg_data} = `SET_PAIR_2;
			4'd3:    {o_reg_addr, o_reg_data} = `SET_PAIR_3;
			4'd4:    {o_reg_addr, o_reg_data} = `SET_PAIR_4;
			4'd5:    {o_reg_addr, o_reg_data} = `SET_PAIR_5;
			4'd6:    {o_reg_addr, o_reg_data} = `SET_PAIR_6;
			4'd7:    {o_reg_addr, o_reg_data} = `SET_PAIR_7;
			4'd8:    {o_reg_addr, o_reg_data} = `SET_PAIR_8;
			4'd9:    {o_reg_addr, o_reg_data} = `SET_PAIR_9;
			4'd10:   {o_reg_addr, o_reg_data} = `SET_PAIR_10;
			4'd11:   {o_reg_addr, o_reg_data} = `SET_PAIR_11;
			4'd12:   {o_reg_addr, o_reg_data} = `SET_PAIR_12;
			4'd13:   {o_reg_addr, o_reg_data} = `SET_PAIR_13;
			default: {o_reg_addr, o_reg_data} = '0; // past the end
		endcase
	end

endmodule

//--- verilog/mpr_sequencer.sv
`timescale 1ns/10ps
`include "touch_defs.svh"

module mpr_sequencer import touch_pkg::*; (
	input  logic                i_CLK,
	input  logic                i_RST,
	input  logic                i_chip_set_req, // level
	input  logic                i_run_req,      // level
	input  logic                i_read_req,     // pulse
	input  data_t               i_read_addr,
	output logic                o_chip_done,
	output logic                o_run_done,
	output mpr_req_t            o_mpr_req,
	input  mpr_rsp_t            i_mpr_rsp,
	output logic                o_touch_valid,
	output logic [`TOUCH_W-1:0] o_touch_status,
	output logic                o_reg_valid,
	output reg_reply_t          o_reg_reply,
	output logic                o_error
);

	mpr_state_e r_state;
	mpr_state_e r_last;      // who started the current transfer
	logic [3:0] r_set_idx;
	logic       r_is_read;
	logic       r_poll_sel;  // 0: status 0x00, 1: status 0x01
	logic       r_read_pend; // pc read waiting for idle
	data_t      r_read_addr;
	data_t      r_touch_lo;  // ele0..7 from the first poll read
	data_t      r_req_addr;
	data_t      r_req_data;
	data_t      w_rom_addr;
	data_t      w_rom_data;
	data_t      w_load_addr;
	data_t      w_load_data;
	logic       w_xfer_end;

	mpr_setting_rom u_rom (
		.i_index    (r_set_idx),
		.o_reg_addr (w_rom_addr),
		.o_reg_data (w_rom_data)
	);

	// enables decoded from state, high only in the en cycle
	assign o_mpr_req.reg_addr = r_req_addr;
	assign o_mpr_req.data_in  = r_req_data;
	assign o_mpr_req.write_en = (r_state == MPR_XFER_EN) & ~r_is_read;
	assign o_mpr_req.read_en  = (r_state == MPR_XFER_EN) & r_is_read;

	assign w_xfer_end = (r_state == MPR_XFER_WAIT) & ~i_mpr_rsp.busy;

	// address/data picked by the requesting state
	always_comb begin
		w_load_addr = r_read_addr; // pc register read
		w_load_data = '0;
		case (r_last)
			MPR_SETTING: begin
				w_load_addr = w_rom_addr;
				w_load_data = w_rom_data;
			end
			MPR_RUN: begin
				w_load_addr = `REG_ELE_CFG;
				w_load_data = `ELE_RUN;
			end
			MPR_STOP: begin
				w_load_addr = `REG_ELE_CFG;
				w_load_data = `ELE_STOP;
			end
			MPR_POLL_LOAD: w_load_addr = r_poll_sel ? `REG_TOUCH1 : `REG_TOUCH0;
			default: ;
		endcase
	end

	// ========================================
	// transaction fsm
	// ========================================
	always_ff @(posedge i_CLK or posedge i_RST) begin
		if (i_RST) begin
			r_state        <= MPR_IDLE;
			r_last         <= MPR_IDLE;
			r_set_idx      <= '0;
			r_is_read      <= 1'b0;
			r_poll_sel     <= 1'b0;
			r_read_pend    <= 1'b0;
			o_chip_done    <= 1'b0;
			o_run_done     <= 1'b0;
			o_touch_valid  <= 1'b0;
			o_touch_status <= '0;
			o_reg_valid    <= 1'b0;
			o_error        <= 1'b0;
		end else begin
			o_touch_valid <= 1'b0; // pulses
			o_reg_valid   <= 1'b0;
			case (r_state)
				MPR_IDLE: begin
					if (i_chip_set_req && !o_chip_done) begin
						r_set_idx <= '0;
						r_state   <= MPR_SETTING;
					end else if (i_run_req && !o_run_done) begin
						r_state <= MPR_RUN;
					end else if (o_run_done && !i_run_req) begin
						r_state <= MPR_STOP; // left running after an error
					end else if (r_read_pend) begin
						r_read_pend <= 1'b0;
						r_last      <= MPR_IDLE;
						r_is_read   <= 1'b1;
						r_state     <= MPR_XFER_LOAD;
					end
				end
				MPR_SETTING, MPR_RUN, MPR_STOP: begin
					r_last    <= r_state; // all three are writes
					r_is_read <= 1'b0;
					r_state   <= MPR_XFER_LOAD;
				end
				MPR_XFER_LOAD: r_state <= MPR_XFER_EN;
				MPR_XFER_EN:   r_state <= MPR_XFER_WAIT;
				MPR_XFER_WAIT: begin
					if (!i_mpr_rsp.busy) begin
						if (i_mpr_rsp.fail) begin
							r_state <= MPR_ERROR;
						end else begin
							case (r_last)
								MPR_SETTING: begin
									r_set_idx <= r_set_idx + 4'd1;
									if (r_set_idx == 4'(`SET_COUNT - 1)) begin
										o_chip_done <= 1'b1; // sticky until reset
										r_state     <= MPR_IDLE;
									end else begin
										r_state <= MPR_SETTING;
									end
								end
								MPR_RUN: begin
									o_run_done <= 1'b1;
									r_poll_sel <= 1'b0; // always start at 0x00
									r_state    <= MPR_POLL_LOAD;
								end
								MPR_STOP: begin
									o_run_done <= 1'b0;
									r_state    <= MPR_IDLE;
								end
								MPR_POLL_LOAD: begin
									if (r_poll_sel) begin // second byte, status complete
										o_touch_status <= {i_mpr_rsp.data_out[3:0], r_touch_lo};
										o_touch_valid  <= 1'b1;
									end
									r_state <= MPR_POLL_CHANGE;
								end
								default: begin
									o_reg_valid <= 1'b1; // pc read done
									r_state     <= MPR_IDLE;
								end
							endcase
						end
					end
				end
				MPR_POLL_LOAD: begin
					if (!i_run_req) begin
						r_state <= MPR_STOP; // stop between reads
					end else begin
						r_last    <= MPR_POLL_LOAD;
						r_is_read <= 1'b1;
						r_state   <= MPR_XFER_LOAD;
					end
				end
				MPR_POLL_CHANGE: begin
					r_poll_sel <= ~r_poll_sel;
					r_state    <= MPR_POLL_LOAD;
				end
				MPR_ERROR: begin
					o_error <= 1'b1;
					r_state <= MPR_IDLE;
				end
				default: r_state <= MPR_IDLE;
			endcase
			if (i_read_req) r_read_pend <= 1'b1; // a new request wins over the clear
		end
	end

	// payload registers
	always_ff @(posedge i_CLK) begin
		if (i_read_req) r_read_addr <= i_read_addr;
		if (r_state == MPR_XFER_LOAD) begin
			r_req_addr <= w_load_addr;
			r_req_data <= w_load_data;
		end
		if (w_xfer_end && r_last == MPR_POLL_LOAD && !r_poll_sel)
			r_touch_lo <= i_mpr_rsp.data_out;
		if (w_xfer_end && r_last == MPR_IDLE)
			o_reg_reply <= '{addr: r_req_addr, data: i_mpr_rsp.data_out};
	end

endmodule

//--- verilog/sensor_ctrl.sv
`timescale 1ns/10ps

module sensor_ctrl import touch_pkg::*; (
	input  logic  i_CLK,
	input  logic  i_RST,
	input  logic  i_init_set,  // i2c engine ready
	input  logic  i_run_mode,
	input  logic  i_read_req,
	input  data_t i_read_addr,
	input  logic  i_chip_done,
	input  logic  i_run_done,
	output logic  o_chip_set_req,
	output logic  o_run_req,
	output logic  o_read_req,
	output data_t o_read_addr,
	output logic  o_chip_set,
	output logic  o_run_set,
	output logic  o_core_busy
);

	core_state_e r_state;

	// ========================================
	// core fsm
	// ========================================
	always_ff @(posedge i_CLK or posedge i_RST) begin
		if (i_RST) begin
			r_state        <= CORE_IDLE;
			o_chip_set_req <= 1'b0;
			o_run_req      <= 1'b0;
			o_read_req     <= 1'b0;
			o_chip_set     <= 1'b0;
			o_run_set      <= 1'b0;
			o_core_busy    <= 1'b0;
		end else begin
			o_chip_set <= i_chip_done; // one cycle behind the sequencer
			o_run_set  <= i_run_done;
			o_read_req <= 1'b0;
			case (r_state)
				CORE_IDLE:      r_state <= CORE_WAIT_INIT;
				CORE_WAIT_INIT: if (i_init_set) r_state <= CORE_CHIP_SET;
				CORE_CHIP_SET: begin
					o_chip_set_req <= ~i_chip_done; // held until the table is written
					if (i_chip_done) r_state <= CORE_STANDBY;
				end
				CORE_STANDBY: begin
					o_run_req  <= i_run_mode;
					o_read_req <= i_read_req & ~i_run_mode; // reads only while stopped
					if (i_run_mode && i_run_done) begin
						o_core_busy <= 1'b1;
						r_state     <= CORE_READING;
					end
				end
				CORE_READING: begin
					o_run_req <= i_run_mode;
					if (!i_run_mode) begin
						o_core_busy <= 1'b0;
						r_state     <= CORE_STANDBY;
					end
				end
				default: r_state <= CORE_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_CLK) begin
		if (i_read_req) o_read_addr <= i_read_addr;
	end

endmodule

//--- verilog/pc_link.sv
`timescale 1ns/10ps
`include "touch_defs.svh"

module pc_link import touch_pkg::*; (
	input  logic                i_CLK,
	input  logic                i_RST,
	input  logic [`RX_W-1:0]    i_rx_data,
	input  logic                i_rx_valid,
	input  logic                i_tx_ready,
	output logic [`TX_W-1:0]    o_tx_data,
	output logic                o_tx_valid,
	output logic                o_run_mode,  // level, R sets and S clears
	output logic                o_read_req,  // pulse on m
	output data_t               o_read_addr,
	input  logic                i_touch_valid,
	input  logic [`TOUCH_W-1:0] i_touch_status,
	input  logic                i_reg_valid,
	input  reg_reply_t          i_reg_reply
);

	logic [`RX_W-1:0]    r_cmd;
	logic                r_cmd_valid;
	pc_cmd_e             w_op;
	logic                r_touch_pend;
	logic                r_reg_pend;
	logic                r_tx_gap;     // low cycle after each frame
	logic [`TOUCH_W-1:0] r_touch_data;
	reg_reply_t          r_reg_data;

	// ========================================
	// command decode
	// ========================================
	assign w_op = pc_cmd_e'(r_cmd[15:8]); // opcode byte

	always_ff @(posedge i_CLK or posedge i_RST) begin
		if (i_RST) begin
			r_cmd_valid <= 1'b0;
			o_run_mode  <= 1'b0;
			o_read_req  <= 1'b0;
		end else begin
			r_cmd_valid <= i_rx_valid;
			o_read_req  <= 1'b0;
			if (r_cmd_valid) begin
				case (w_op)
					CMD_RUN:      o_run_mode <= 1'b1;
					CMD_STOP:     o_run_mode <= 1'b0;
					CMD_READ_REG: o_read_req <= 1'b1;
					default: ; // unknown opcode dropped
				endcase
			end
		end
	end

	// ========================================
	// frame output
	// ========================================
	// touch frame has priority over a register reply
	assign o_tx_valid = i_tx_ready & ~r_tx_gap & (r_touch_pend | r_reg_pend);
	assign o_tx_data  = r_touch_pend ?
		{`TAG_TOUCH, 4'b0, r_touch_data, 8'h00} :
		{`TAG_REG, r_reg_data.addr, r_reg_data.data, 8'h00};

	always_ff @(posedge i_CLK or posedge i_RST) begin
		if (i_RST) begin
			r_touch_pend <= 1'b0;
			r_reg_pend   <= 1'b0;
			r_tx_gap     <= 1'b0;
		end else begin
			r_tx_gap <= o_tx_valid;
			if (o_tx_valid && r_touch_pend) r_touch_pend <= 1'b0;
			if (o_tx_valid && !r_touch_pend) r_reg_pend <= 1'b0;
			if (i_touch_valid) r_touch_pend <= 1'b1; // newer status replaces unsent one
			if (i_reg_valid) r_reg_pend <= 1'b1;
		end
	end

	always_ff @(posedge i_CLK) begin
		if (i_rx_valid) r_cmd <= i_rx_data;
		if (r_cmd_valid) o_read_addr <= r_cmd[7:0]; // argument byte
		if (i_touch_valid) r_touch_data <= i_touch_status;
		if (i_reg_valid) r_reg_data <= i_reg_reply;
	end

endmodule

//--- verilog/touch_sensor_top.sv
`timescale 1ns/10ps
`include "touch_defs.svh"

module touch_sensor_top (
	input  logic                i_CLK,
	input  logic                i_RST,
	input  logic [`RX_W-1:0]    i_uart_rx_data,
	input  logic                i_uart_rx_valid,
	input  logic                i_uart_tx_ready,
	output logic [`TX_W-1:0]    o_uart_tx_data,
	output logic                o_uart_tx_valid,
	output touch_pkg::mpr_req_t o_mpr_req,
	input  touch_pkg::mpr_rsp_t i_mpr_rsp,
	output logic [`TOUCH_W-1:0] o_touch_status,
	output logic                o_mpr_error,
	output logic                o_chip_set,
	output logic                o_run_set,
	output logic                o_core_busy
);

	logic                  w_run_mode;
	logic                  w_pc_read_req;   // pc_link to sensor_ctrl
	touch_pkg::data_t      w_pc_read_addr;
	logic                  w_seq_read_req;  // sensor_ctrl to sequencer
	touch_pkg::data_t      w_seq_read_addr;
	logic                  w_chip_set_req;
	logic                  w_run_req;
	logic                  w_chip_done;
	logic                  w_run_done;
	logic                  w_touch_valid;
	logic                  w_reg_valid;
	touch_pkg::reg_reply_t w_reg_reply;

	pc_link u_pc_link (
		.i_CLK (i_CLK), .i_RST (i_RST),
		.i_rx_data (i_uart_rx_data), .i_rx_valid (i_uart_rx_valid),
		.i_tx_ready (i_uart_tx_ready),
		.o_tx_data (o_uart_tx_data), .o_tx_valid (o_uart_tx_valid),
		.o_run_mode (w_run_mode), .o_read_req (w_pc_read_req), .o_read_addr (w_pc_read_addr),
		.i_touch_valid (w_touch_valid), .i_touch_status (o_touch_status),
		.i_reg_valid (w_reg_valid), .i_reg_reply (w_reg_reply)
	);

	sensor_ctrl u_sensor_ctrl (
		.i_CLK (i_CLK), .i_RST (i_RST), .i_init_set (i_mpr_rsp.init_set),
		.i_run_mode (w_run_mode), .i_read_req (w_pc_read_req), .i_read_addr (w_pc_read_addr),
		.i_chip_done (w_chip_done), .i_run_done (w_run_done),
		.o_chip_set_req (w_chip_set_req), .o_run_req (w_run_req),
		.o_read_req (w_seq_read_req), .o_read_addr (w_seq_read_addr),
		.o_chip_set (o_chip_set), .o_run_set (o_run_set), .o_core_busy (o_core_busy)
	);

	mpr_sequencer u_mpr_sequencer (
		.i_CLK (i_CLK), .i_RST (i_RST),
		.i_chip_set_req (w_chip_set_req), .i_run_req (w_run_req),
		.i_read_req (w_seq_read_req), .i_read_addr (w_seq_read_addr),
		.o_chip_done (w_chip_done), .o_run_done (w_run_done),
		.o_mpr_req (o_mpr_req), .i_mpr_rsp (i_mpr_rsp),
		.o_touch_valid (w_touch_valid), .o_touch_status (o_touch_status),
		.o_reg_valid (w_reg_valid), .o_reg_reply (w_reg_reply), .o_error (o_mpr_error)
	);

endmodule

//--- testbench/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
	parameter real period_ns = 8.0
) (
	output logic o_clk
);

	initial o_clk = 1'b0;

	always #(period_ns / 2.0) o_clk = ~o_clk; // 4 ns high, 4 ns low

endmodule

//--- testbench/touch_checker.sv
`timescale 1ns/10ps

module touch_checker (
	input logic i_CLK,
	input logic i_RST,
	input logic i_write_en,
	input logic i_read_en,
	input logic i_tx_valid,
	input logic i_tx_ready,
	input logic i_chip_set
);

	// ========================================
	// i2c strobes
	// ========================================
	a_one_enable: assert property (@(posedge i_CLK) disable iff (i_RST)
		!(i_write_en && i_read_en)) else $error("write and read enable high together");
	a_write_pulse: assert property (@(posedge i_CLK) disable iff (i_RST)
		i_write_en |=> !i_write_en) else $error("write enable longer than one cycle");
	a_read_pulse: assert property (@(posedge i_CLK) disable iff (i_RST)
		i_read_en |=> !i_read_en) else $error("read enable longer than one cycle");

	// uart side and status
	a_tx_ready: assert property (@(posedge i_CLK) disable iff (i_RST)
		i_tx_valid |-> i_tx_ready) else $error("frame sent while uart not ready");
	a_chip_set_hold: assert property (@(posedge i_CLK) disable iff (i_RST)
		i_chip_set |=> i_chip_set) else $error("chip set dropped without reset");

endmodule

bind touch_sensor_top touch_checker u_touch_checker (
	.i_CLK (i_CLK), .i_RST (i_RST),
	.i_write_en (o_mpr_req.write_en), .i_read_en (o_mpr_req.read_en),
	.i_tx_valid (o_uart_tx_valid), .i_tx_ready (i_uart_tx_ready),
	.i_chip_set (o_chip_set)
);

//--- testbench/tb_touch_sensor.sv
`timescale 1ns/10ps
`include "touch_defs.svh"

module tb_touch_sensor import touch_pkg::*; ();

	localparam int cycle_limit = 4000; // full run needs about 500 cycles

	logic clk, rst, rx_valid, tx_ready, tx_valid;
	logic mpr_error, chip_set, run_set, core_busy;
	logic init_set, fail_next_read;      // engine controls from the tests
	logic rsp_busy, rsp_fail;
	logic [`RX_W-1:0] rx_data;
	logic [`TX_W-1:0] tx_data;
	logic [`TOUCH_W-1:0] touch_status;
	mpr_req_t mpr_req;
	mpr_rsp_t mpr_rsp;
	data_t rsp_data;
	data_t image [0:255];                // mpr121 register image
	data_t log_addr [$];                 // every write, in order
	data_t log_data [$];
	logic [`TX_W-1:0] frames [$];        // frames taken by the pc
	int busy_left, read_count, cycle_count;

	// recommended setting pairs {addr, data}, table order
	logic [15:0] set_table [0:13] = '{16'h2B01, 16'h2C01, 16'h2D0E, 16'h2E00, 16'h2F01,
		16'h3005, 16'h3101, 16'h3200, 16'h3300, 16'h3400, 16'h3500, 16'h5B00, 16'h5C10, 16'h5D20};

	assign mpr_rsp = '{data_out: rsp_data, init_set: init_set, busy: rsp_busy, fail: rsp_fail};

	tb_clock_gen u_clock_gen (.o_clk (clk));

	touch_sensor_top UUT (
		.i_CLK (clk), .i_RST (rst),
		.i_uart_rx_data (rx_data), .i_uart_rx_valid (rx_valid), .i_uart_tx_ready (tx_ready),
		.o_uart_tx_data (tx_data), .o_uart_tx_valid (tx_valid),
		.o_mpr_req (mpr_req), .i_mpr_rsp (mpr_rsp), .o_touch_status (touch_status),
		.o_mpr_error (mpr_error), .o_chip_set (chip_set), .o_run_set (run_set),
		.o_core_busy (core_busy)
	);

	// ========================================
	// i2c engine model
	// ========================================
	initial begin
		integer seed;
		seed = 32'he6bd;
		rsp_data <= '0;
		rsp_busy <= 1'b0;
		rsp_fail <= 1'b0;
		for (int i = 0; i < 256; i++) image[i] = 8'($random(seed));
		forever begin
			@(posedge clk);
			if (mpr_req.write_en) begin
				image[mpr_req.reg_addr] = mpr_req.data_in;
				log_addr.push_back(mpr_req.reg_addr);
				log_data.push_back(mpr_req.data_in);
			end
			if (mpr_req.read_en) begin
				read_count <= read_count + 1;
				rsp_data   <= image[mpr_req.reg_addr];
			end
			if (mpr_req.write_en || mpr_req.read_en) begin
				rsp_busy  <= 1'b1;                          // busy for 3 cycles
				rsp_fail  <= fail_next_read & mpr_req.read_en; // seen when busy drops
				busy_left <= 3;
			end else if (busy_left > 0) begin
				busy_left <= busy_left - 1;
				if (busy_left == 1) rsp_busy <= 1'b0;
			end
		end
	end

	always @(posedge clk) begin
		if (tx_valid) frames.push_back(tx_data); // pc takes every valid frame
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("timeout, the run did not finish within %0d cycles", cycle_limit);
			$display("Simulation FAILED");
			$fatal(1, "cycle limit reached");
		end
	end

	// ========================================
	// helpers and tests
	// ========================================
	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("FAILED %s: got 0x%h, expected 0x%h", name, got, expected);
			$display("Simulation FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic send_cmd(input data_t op, input data_t arg);
		@(posedge clk);
		rx_data  <= {op, arg};
		rx_valid <= 1'b1;
		@(posedge clk);
		rx_valid <= 1'b0;
	endtask

	task automatic check_reset_state();
		check_value("o_uart_tx_valid", tx_valid, 0);
		check_value("o_mpr_req.write_en", mpr_req.write_en, 0);
		check_value("o_mpr_req.read_en", mpr_req.read_en, 0);
		check_value("o_chip_set", chip_set, 0);
		check_value("o_run_set", run_set, 0);
		check_value("o_core_busy", core_busy, 0);
		check_value("o_mpr_error", mpr_error, 0);
		check_value("o_touch_status", touch_status, 0);
	endtask

	task automatic run_chip_setting();
		@(posedge clk);
		init_set <= 1'b1; // engine ready
		while (!chip_set) @(negedge clk);
		check_value("write count", log_addr.size(), 14);
		for (int i = 0; i < 14; i++) begin
			check_value("o_mpr_req.reg_addr", log_addr[i], set_table[i][15:8]);
			check_value("o_mpr_req.data_in", log_data[i], set_table[i][7:0]);
		end
	endtask

	task automatic start_polling();
		int base_log;
		int base_frame;
		base_log = log_addr.size();
		send_cmd(`OP_RUN, 8'h00);
		while (!core_busy) @(negedge clk);
		check_value("o_run_set", run_set, 1);
		check_value("write count", log_addr.size(), base_log + 1);
		check_value("o_mpr_req.reg_addr", log_addr[base_log], 8'h5E);
		check_value("o_mpr_req.data_in", log_data[base_log], 8'h8F);
		base_frame = frames.size();
		while (frames.size() < base_frame + 3) @(negedge clk);
		for (int k = 0; k < 3; k++)
			check_value("o_uart_tx_data", frames[base_frame + k],
				{8'hBB, 4'h0, image[1][3:0], image[0], 8'h00});
		check_value("o_touch_status", touch_status, {image[1][3:0], image[0]});
	endtask

	task automatic stop_polling();
		int base_log;
		int reads;
		base_log = log_addr.size();
		send_cmd(`OP_STOP, 8'h00);
		while (core_busy || run_set) @(negedge clk); // stop write done
		check_value("write count", log_addr.size(), base_log + 1);
		check_value("o_mpr_req.reg_addr", log_addr[base_log], 8'h5E);
		check_value("o_mpr_req.data_in", log_data[base_log], 8'h00);
		reads = read_count;
		repeat (100) @(negedge clk);
		check_value("status read count", read_count, reads);
	endtask

	task automatic read_register(input data_t addr);
		int base_frame;
		base_frame = frames.size();
		@(posedge clk);
		tx_ready <= 1'b0; // pc stalls the uart
		send_cmd(`OP_READ_REG, addr);
		repeat (50) @(negedge clk);
		check_value("frame count while stalled", frames.size(), base_frame);
		@(posedge clk);
		tx_ready <= 1'b1;
		while (frames.size() == base_frame) @(negedge clk);
		repeat (20) @(negedge clk);
		check_value("reply frame count", frames.size(), base_frame + 1);
		check_value("o_uart_tx_data", frames[base_frame], {8'h6D, addr, image[addr], 8'h00});
	endtask

	task automatic read_with_fail();
		int base_frame;
		check_value("o_mpr_error", mpr_error, 0);
		base_frame = frames.size();
		@(posedge clk);
		fail_next_read <= 1'b1;
		send_cmd(`OP_READ_REG, 8'h10);
		while (!mpr_error) @(negedge clk);
		repeat (30) @(negedge clk);
		check_value("o_mpr_error", mpr_error, 1); // sticky
		check_value("frame count after fail", frames.size(), base_frame);
	endtask

	initial begin
		rst            <= 1'b1;
		rx_data        <= '0;
		rx_valid       <= 1'b0;
		tx_ready       <= 1'b1;
		init_set       <= 1'b0;
		fail_next_read <= 1'b0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_reset_state();
		run_chip_setting();
		start_polling();
		stop_polling();
		read_register(8'hA7); // not touched by the design
		read_with_fail();
		$display("Simulation PASSED");
		$finish;
	end

endmodule

//--- project.f
+incdir+verilog
verilog/touch_pkg.sv
verilog/mpr_setting_rom.sv
verilog/mpr_sequencer.sv
verilog/sensor_ctrl.sv
verilog/pc_link.sv
verilog/touch_sensor_top.sv
testbench/tb_clock_gen.sv
testbench/touch_checker.sv
testbench/tb_touch_sensor.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the touch sensor testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --timescale 1ns/10ps -Wno-fatal \
	--top-module tb_touch_sensor -f project.f --Mdir obj_dir -o tb_touch_sensor \
	> build.log 2>&1
if [ $? -ne 0 ]; then
	echo "verilator build failed, see build.log"
	exit 1
fi

./obj_dir/tb_touch_sensor > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "Simulation PASSED" sim.log; then
	echo "result: pass"
	exit 0
else
	echo "result: fail"
	exit 1
fi
